// ==== verilog/pixel_pkg.sv ====
`default_nettype none

//////////////////////////////////////////////////
// Widths and types shared by the pixel reader
//////////////////////////////////////////////////

package pixel_pkg;

    // Frame buffer word
    localparam int word_w = 32;

    // One packed 24-bit pixel
    localparam int pix_w = 24;

    // Word address, 1024 words deep
    localparam int addr_w = 10;

    // Group count of a job
    localparam int grp_w = 8;

    // Four pixels fill exactly three words
    localparam int words_per_grp = 3;

    typedef logic [word_w-1:0] word_t;
    typedef logic [pix_w-1:0]  pixel_t;
    typedef logic [addr_w-1:0] addr_t;

endpackage

`default_nettype wire

// ==== verilog/frame_bram.sv ====
`timescale 1ns/1ns
`default_nettype none

// Frame buffer, one write port and one registered read port
module frame_bram
    import pixel_pkg::*;
(
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  word_t wr_data,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output word_t rd_data
);

    // Storage array, maps onto block RAM
    word_t mem [2**addr_w];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read port with output register
    // Same-address write in the same cycle returns the old word
    // Output holds its word while no read is issued
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/word_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

// Address sequencer, three reads per group then one idle slot
module word_fetch
    import pixel_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  addr_t            base_addr,
    input  logic [grp_w-1:0] grp_count,
    input  word_t            rd_data,
    input  logic             ostall,
    output logic             rd_en,
    output addr_t            rd_addr,
    output word_t            idat,
    output logic             ival,
    output logic             busy,
    output logic             done
);

    logic             accept;
    logic             fetching;
    logic [1:0]       slot;
    logic [grp_w-1:0] grps_left;
    logic             park;
    logic             idle_step;
    logic             hold_pend;
    logic             hold_sel;
    word_t            hold_word;
    logic             last_word;

    // Start is ignored while a job runs
    assign accept = start & ~busy;

    // Read in flight while the unpacker stalls, its word lands in the gap
    assign park = ostall & rd_en;

    // End of a group, idle slot reached
    assign idle_step = fetching & ~park & (slot == 2'(words_per_grp));

    // Final word of the job, nothing issued or parked behind it
    assign last_word = ival & ostall & ~fetching & ~rd_en & ~hold_pend;

    //////////////////////////////////////////////////
    // Job status
    //////////////////////////////////////////////////

    // Done lines up with the cached pixel after the last stall
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= busy & last_word;
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Read issue
    //////////////////////////////////////////////////

    // Slot holds the word index to issue at the next edge
    always_ff @(posedge clk) begin
        if (rst) begin
            fetching <= 1'b0;
            slot     <= 2'd0;
            rd_en    <= 1'b0;
        end else if (accept) begin
            fetching <= 1'b1;
            slot     <= 2'd0;
            rd_en    <= 1'b0;
        end else if (idle_step) begin
            // Gap cycle for the cached pixel
            rd_en <= 1'b0;
            slot  <= 2'd0;
            if (grps_left == grp_w'(1)) begin
                fetching <= 1'b0;
            end
        end else if (fetching && !park) begin
            rd_en <= 1'b1;
            slot  <= slot + 2'd1;
        end else begin
            // Parked word pushes the next read back one cycle
            rd_en <= 1'b0;
        end
    end

    // Address steps after every issued read
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_addr   <= base_addr;
            grps_left <= grp_count;
        end else begin
            if (rd_en) begin
                rd_addr <= rd_addr + 1'b1;
            end
            if (idle_step) begin
                grps_left <= grps_left - 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Word stream to the unpacker
    //////////////////////////////////////////////////

    // Valid trails the read by one cycle, parked word comes one later
    always_ff @(posedge clk) begin
        if (rst) begin
            ival      <= 1'b0;
            hold_pend <= 1'b0;
            hold_sel  <= 1'b0;
        end else begin
            ival      <= (rd_en & ~park) | hold_pend;
            hold_pend <= park;
            hold_sel  <= hold_pend;
        end
    end

    // Hold register catches the word that arrives in the gap
    always_ff @(posedge clk) begin
        if (hold_pend) begin
            hold_word <= rd_data;
        end
    end

    assign idat = hold_sel ? hold_word : rd_data;

endmodule

`default_nettype wire

// ==== verilog/pixel_concat.sv ====
`timescale 1ns/1ns
`default_nettype none

// Unpacker, 32-bit words in, 24-bit pixels out
module pixel_concat
    import pixel_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  word_t  idat,
    input  logic   ival,
    output pixel_t odat,
    output logic   oval,
    output logic   ostall
);

    word_t                 cache;
    logic [1:0]            state;
    logic                  stall_q;
    logic [2*word_w-1:0]   joined;

    //////////////////////////////////////////////////
    // Word cache and alignment
    //////////////////////////////////////////////////

    // Previous valid word, low half of the joined window
    always_ff @(posedge clk) begin
        if (ival) begin
            cache <= idat;
        end
    end

    // Alignment moves on with every pixel out
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= 2'd0;
        end else if (oval) begin
            state <= state + 2'd1;
        end
    end

    // Third word of a group leaves a whole pixel in the cache
    assign ostall = (state == 2'd2) & ival;

    // Gap cycle after the stall emits the cached pixel
    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= ostall;
        end
    end

    //////////////////////////////////////////////////
    // Pixel select
    //////////////////////////////////////////////////

    // Current word above the cached one
    assign joined = {idat, cache};

    // Byte 3p of the image lands in the low bits
    always_comb begin
        case (state)
            // Lanes 0..2 of the current word
            2'd0: odat = joined[8*7-1:8*4];
            // Cached lane 3, current lanes 0..1
            2'd1: odat = joined[8*6-1:8*3];
            // Cached lanes 2..3, current lane 0
            2'd2: odat = joined[8*5-1:8*2];
            // Cached lanes 1..3 only
            default: odat = joined[8*4-1:8*1];
        endcase
    end

    // Alignment 3 has no input word
    assign oval = (state == 2'd3) ? stall_q : ival;

endmodule

`default_nettype wire

// ==== verilog/image_pixel_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

// Frame buffer to pixel stream, top level
module image_pixel_reader
    import pixel_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    // Load port
    input  logic             wr_en,
    input  addr_t            wr_addr,
    input  word_t            wr_data,
    // Job start
    input  logic             start,
    input  addr_t            base_addr,
    input  logic [grp_w-1:0] grp_count,
    // Pixel stream
    output pixel_t           pix_data,
    output logic             pix_valid,
    // Status
    output logic             busy,
    output logic             done
);

    // Read port
    logic  rd_en;
    addr_t rd_addr;
    word_t rd_data;

    // Word stream
    word_t idat;
    logic  ival;
    logic  ostall;

    //////////////////////////////////////////////////
    // Frame buffer
    //////////////////////////////////////////////////

    frame_bram bram_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Fetch unit, paced by the unpacker stall
    word_fetch fetch_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .base_addr (base_addr),
        .grp_count (grp_count),
        .rd_data   (rd_data),
        .ostall    (ostall),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .idat      (idat),
        .ival      (ival),
        .busy      (busy),
        .done      (done)
    );

    // Unpacker drives the pixel port directly
    pixel_concat concat_i (
        .clk    (clk),
        .rst    (rst),
        .idat   (idat),
        .ival   (ival),
        .odat   (pix_data),
        .oval   (pix_valid),
        .ostall (ostall)
    );

endmodule

`default_nettype wire

// ==== test/image_pixel_reader_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

// Strobe rules of the unpacker, bound into pixel_concat
module image_pixel_reader_assert (
    input logic clk,
    input logic rst,
    input logic ival,
    input logic oval,
    input logic ostall
);

    //////////////////////////////////////////////////
    // Word stream handshake
    //////////////////////////////////////////////////

    // Cached pixel goes out in the cycle after a stall
    stall_then_pixel: assert property (@(posedge clk) disable iff (rst) ostall |=> oval)
        else $error("oval low in the cycle after ostall");

    // Gap cycle belongs to the cached pixel
    gap_after_stall: assert property (@(posedge clk) disable iff (rst) ostall |=> !ival)
        else $error("ival high in the cycle after ostall");

    // Nothing left over from before reset
    quiet_after_reset: assert property (@(posedge clk) rst |=> !oval)
        else $error("oval high in the cycle after reset");

endmodule

`default_nettype wire

// ==== test/image_pixel_reader_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module image_pixel_reader_tb
    import pixel_pkg::*;
;

    localparam int n_bytes        = 4 * 2**addr_w;
    localparam int load_cycles    = 64 + 2**addr_w;
    localparam int n_jobs         = 24;
    localparam int max_job_cycles = 4 * 16 + 10;
    // Twice the worst case of all loads and jobs
    localparam int cycle_limit    = 2 * (load_cycles + n_jobs * max_job_cycles);

    logic             clk;
    logic             rst;
    logic             wr_en;
    addr_t            wr_addr;
    word_t            wr_data;
    logic             start;
    addr_t            base_addr;
    logic [grp_w-1:0] grp_count;
    pixel_t           pix_data;
    logic             pix_valid;
    logic             busy;
    logic             done;

    // Byte image of the buffer, byte k in word k/4, lane k mod 4
    logic [7:0] img_bytes [n_bytes];
    pixel_t     exp_q [$];
    integer     seed;
    int         cycle_count = 0;
    int         error_count = 0;
    int         pix_count   = 0;
    int         job_grps    = 0;
    logic       streaming   = 1'b0;
    logic       done_q      = 1'b0;

    image_pixel_reader dut_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .start     (start),
        .base_addr (base_addr),
        .grp_count (grp_count),
        .pix_data  (pix_data),
        .pix_valid (pix_valid),
        .busy      (busy),
        .done      (done)
    );

    // Strobe checks on the unpacker
    bind pixel_concat image_pixel_reader_assert assert_i (
        .clk    (clk),
        .rst    (rst),
        .ival   (ival),
        .oval   (oval),
        .ostall (ostall)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////

    task automatic fail_run(input string what);
        error_count++;
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic value_error(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        fail_run($sformatf("error: time %0t %s expected %h actual %h",
                           $time, name, expv, actv));
    endtask

    // Run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout, run exceeded %0d cycles", cycle_limit));
        end
    end

    //////////////////////////////////////////////////
    // Model and stimulus
    //////////////////////////////////////////////////

    // Pixel p of a job, bytes 3p..3p+2 with 3p low
    function automatic pixel_t model_pixel(input addr_t base, input int p);
        int     k;
        pixel_t pix;
        k = 4 * int'(base) + 3 * p;
        for (int b = 0; b < 3; b++) begin
            pix[8*b +: 8] = img_bytes[(k + b) % n_bytes];
        end
        return pix;
    endfunction

    task automatic load_words(input int first, input int count);
        word_t d;
        for (int i = 0; i < count; i++) begin
            d = word_t'($random(seed));
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = addr_t'(first + i);
            wr_data = d;
            for (int lane = 0; lane < 4; lane++) begin
                img_bytes[(4 * (first + i) + lane) % n_bytes] = d[8*lane +: 8];
            end
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Queue the expected pixels, then pulse start
    task automatic start_job(input addr_t base, input int grps);
        for (int p = 0; p < 4 * grps; p++) begin
            exp_q.push_back(model_pixel(base, p));
        end
        job_grps  = grps;
        pix_count = 0;
        @(negedge clk);
        start     = 1'b1;
        base_addr = base;
        grp_count = grp_w'(grps);
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input int grps);
        int waited;
        waited = 0;
        while (!done) begin
            @(negedge clk);
            waited++;
            assert (waited <= 4 * grps + 10) else fail_run("job never raised done");
        end
        // Monitor sees done and the cycle after
        repeat (2) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin : monitor
        pixel_t exp_pix;
        if (rst) begin
            exp_q.delete();
            streaming = 1'b0;
            done_q    = 1'b0;
        end else begin
            if (done_q) assert (!busy) else fail_run("busy still high after done");
            // No gaps once the first pixel is out
            if (streaming) assert (pix_valid) else fail_run("gap in the pixel stream");
            if (pix_valid) begin
                assert (exp_q.size() > 0) else fail_run("pixel out with no job pending");
                exp_pix = exp_q.pop_front();
                pix_count++;
                assert (pix_data == exp_pix) else value_error("pix_data", exp_pix, pix_data);
                streaming = (exp_q.size() > 0);
                assert (done == !streaming) else fail_run("done not on the last pixel");
            end else begin
                assert (!done) else fail_run("done without a pixel");
            end
            if (done) begin
                assert (pix_count == 4 * job_grps)
                    else value_error("pixel count", 4 * job_grps, pix_count);
            end
            done_q = done;
        end
    end

    initial begin : stimulus
        addr_t base;
        int    grps;
        seed      = 32'ha6d0_abd9;
        rst       = 1'b1;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        start     = 1'b0;
        base_addr = '0;
        grp_count = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        // Small load, one group at address 0
        load_words(0, 64);
        start_job(addr_t'(0), 1);
        wait_done(1);

        // Full buffer, random jobs
        load_words(0, 2**addr_w);
        for (int j = 0; j < 20; j++) begin
            base = addr_t'($random(seed));
            grps = 1 + ($unsigned($random(seed)) % 16);
            start_job(base, grps);
            wait_done(grps);
        end

        // Second start while busy must be dropped
        start_job(addr_t'($random(seed)), 8);
        repeat (5) @(negedge clk);
        assert (busy) else fail_run("busy low in the middle of a job");
        start     = 1'b1;
        base_addr = addr_t'($random(seed));
        grp_count = grp_w'(3);
        @(negedge clk);
        start = 1'b0;
        wait_done(8);
        repeat (10) begin
            @(negedge clk);
            assert (!busy) else fail_run("ignored start launched a job");
        end

        // Reset in the middle of a job
        start_job(addr_t'($random(seed)), 8);
        repeat (12) @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!pix_valid && !busy && !done) else fail_run("outputs not cleared by reset");
        grps = 1 + ($unsigned($random(seed)) % 16);
        start_job(addr_t'($random(seed)), grps);
        wait_done(grps);

        repeat (4) @(negedge clk);
        assert (exp_q.size() == 0) else fail_run("expected pixels never came out");
        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("checks failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
verilog/pixel_pkg.sv
verilog/frame_bram.sv
verilog/word_fetch.sv
verilog/pixel_concat.sv
verilog/image_pixel_reader.sv
test/image_pixel_reader_assert.sv
test/image_pixel_reader_tb.sv

// ==== Bender.yml ====
package:
  name: image_pixel_reader

sources:
  - verilog/pixel_pkg.sv
  - verilog/frame_bram.sv
  - verilog/word_fetch.sv
  - verilog/pixel_concat.sv
  - verilog/image_pixel_reader.sv
  - target: test
    files:
      - test/image_pixel_reader_assert.sv
      - test/image_pixel_reader_tb.sv
